// ==== common/rv_isa_pkg.sv ====
package rv_isa_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [6:0]  opcode_t;
    typedef logic [2:0]  funct3_t;

    // Major opcodes
    localparam opcode_t OP_LUI    = 7'b0110111;
    localparam opcode_t OP_AUIPC  = 7'b0010111;
    localparam opcode_t OP_JAL    = 7'b1101111;
    localparam opcode_t OP_JALR   = 7'b1100111;
    localparam opcode_t OP_BRANCH = 7'b1100011;
    localparam opcode_t OP_LOAD   = 7'b0000011;
    localparam opcode_t OP_STORE  = 7'b0100011;
    localparam opcode_t OP_IMM    = 7'b0010011;
    localparam opcode_t OP_REG    = 7'b0110011;

    // ALU funct3 for OP_REG and OP_IMM
    localparam funct3_t F3_ADD  = 3'b000;
    localparam funct3_t F3_SLL  = 3'b001;
    localparam funct3_t F3_SLT  = 3'b010;
    localparam funct3_t F3_SLTU = 3'b011;
    localparam funct3_t F3_XOR  = 3'b100;
    localparam funct3_t F3_SR   = 3'b101;
    localparam funct3_t F3_OR   = 3'b110;
    localparam funct3_t F3_AND  = 3'b111;

    // Branch conditions
    localparam funct3_t F3_BEQ  = 3'b000;
    localparam funct3_t F3_BNE  = 3'b001;
    localparam funct3_t F3_BLT  = 3'b100;
    localparam funct3_t F3_BGE  = 3'b101;
    localparam funct3_t F3_BLTU = 3'b110;
    localparam funct3_t F3_BGEU = 3'b111;

endpackage

// ==== common/ex_pipe_pkg.sv ====
package ex_pipe_pkg;

    // Operand source for the forwarding muxes
    typedef logic [1:0] fwd_sel_t;

    localparam fwd_sel_t FWD_RF  = 2'b00;
    localparam fwd_sel_t FWD_WB  = 2'b01;
    localparam fwd_sel_t FWD_MEM = 2'b10;

endpackage

// ==== common/bypass_if.sv ====
interface bypass_if
    import rv_isa_pkg::*;
();

    // EX/MEM side, from the pipeline register
    reg_idx_t mem_rd;
    logic     mem_reg_write;
    logic     mem_is_load;
    word_t    mem_result;

    // MEM/WB side, from the write-back stage
    reg_idx_t wb_rd;
    logic     wb_write;
    word_t    wb_data;

    modport source (
        output mem_rd,
        output mem_reg_write,
        output mem_is_load,
        output mem_result
    );

    modport sink (
        input mem_rd,
        input mem_reg_write,
        input mem_is_load,
        input mem_result,
        input wb_rd,
        input wb_write,
        input wb_data
    );

endinterface

// ==== execute/forward_unit.sv ====
module forward_unit
    import rv_isa_pkg::*;
    import ex_pipe_pkg::*;
(
    input  reg_idx_t      rs1,
    input  reg_idx_t      rs2,
    bypass_if.sink        byp,
    output fwd_sel_t      sel_a,
    output fwd_sel_t      sel_b
);

    logic mem_ok;
    logic wb_ok;

    // Loads have no data yet in EX/MEM, and x0 is never forwarded
    assign mem_ok = byp.mem_reg_write && !byp.mem_is_load && (byp.mem_rd != '0);
    assign wb_ok  = byp.wb_write && (byp.wb_rd != '0);

    function automatic fwd_sel_t pick(input reg_idx_t rs, input logic m_ok,
                                      input reg_idx_t m_rd, input logic w_ok,
                                      input reg_idx_t w_rd);
        if (m_ok && (m_rd == rs)) begin
            return FWD_MEM;
        end else if (w_ok && (w_rd == rs)) begin
            return FWD_WB;
        end
        return FWD_RF;
    endfunction

    assign sel_a = pick(rs1, mem_ok, byp.mem_rd, wb_ok, byp.wb_rd);
    assign sel_b = pick(rs2, mem_ok, byp.mem_rd, wb_ok, byp.wb_rd);

endmodule

// ==== execute/alu.sv ====
module alu
    import rv_isa_pkg::*;
(
    input  opcode_t opcode,
    input  funct3_t funct3,
    input  logic    funct7_5,
    input  word_t   op_a,
    input  word_t   op_b,
    output word_t   result
);

    logic       is_int_op;
    logic       do_sub;
    logic [4:0] shamt;
    word_t      int_result;

    assign is_int_op = (opcode == OP_REG) || (opcode == OP_IMM);

    // Bit 30 of an I-type add is immediate, not sub
    assign do_sub = (opcode == OP_REG) && funct7_5;

    assign shamt = op_b[4:0];

    always_comb begin
        case (funct3)
            F3_ADD: begin
                if (do_sub) begin
                    int_result = op_a - op_b;
                end else begin
                    int_result = op_a + op_b;
                end
            end
            F3_SLL: begin
                int_result = op_a << shamt;
            end
            F3_SLT: begin
                int_result = word_t'($signed(op_a) < $signed(op_b));
            end
            F3_SLTU: begin
                int_result = word_t'(op_a < op_b);
            end
            F3_XOR: begin
                int_result = op_a ^ op_b;
            end
            F3_SR: begin
                // Arithmetic shift for both sra and srai
                if (funct7_5) begin
                    int_result = word_t'($signed(op_a) >>> shamt);
                end else begin
                    int_result = op_a >> shamt;
                end
            end
            F3_OR: begin
                int_result = op_a | op_b;
            end
            default: begin
                int_result = op_a & op_b;
            end
        endcase
    end

    // Address generation for loads and stores
    assign result = is_int_op ? int_result : (op_a + op_b);

endmodule

// ==== execute/branch_unit.sv ====
module branch_unit
    import rv_isa_pkg::*;
(
    input  opcode_t opcode,
    input  funct3_t funct3,
    input  word_t   pc,
    input  word_t   rs1_val,
    input  word_t   rs2_val,
    input  word_t   imm,
    output logic    taken,
    output word_t   target,
    output word_t   link
);

    logic  cond;
    logic  is_jump;
    word_t jalr_sum;

    always_comb begin
        case (funct3)
            F3_BEQ:  cond = (rs1_val == rs2_val);
            F3_BNE:  cond = (rs1_val != rs2_val);
            F3_BLT:  cond = ($signed(rs1_val) < $signed(rs2_val));
            F3_BGE:  cond = ($signed(rs1_val) >= $signed(rs2_val));
            F3_BLTU: cond = (rs1_val < rs2_val);
            F3_BGEU: cond = (rs1_val >= rs2_val);
            default: cond = 1'b0;
        endcase
    end

    assign is_jump  = (opcode == OP_JAL) || (opcode == OP_JALR);
    assign taken    = is_jump || ((opcode == OP_BRANCH) && cond);
    assign jalr_sum = rs1_val + imm;

    // JALR drops bit 0 of the sum
    assign target = (opcode == OP_JALR) ? {jalr_sum[31:1], 1'b0} : (pc + imm);
    assign link   = pc + 32'd4;

endmodule

// ==== execute/execute_stage.sv ====
module execute_stage
    import rv_isa_pkg::*;
    import ex_pipe_pkg::*;
(
    input  logic     valid,
    input  word_t    instr,
    input  word_t    pc,
    input  word_t    rs1_data,
    input  word_t    rs2_data,
    bypass_if.sink   byp,
    output word_t    result,
    output word_t    store_data,
    output reg_idx_t rd,
    output logic     reg_write,
    output logic     mem_read,
    output logic     mem_write,
    output funct3_t  funct3,
    output logic     branch_taken,
    output word_t    branch_target
);

    opcode_t  opcode;
    reg_idx_t rs1;
    reg_idx_t rs2;
    word_t    imm;
    word_t    fwd_a;
    word_t    fwd_b;
    word_t    alu_b;
    word_t    alu_out;
    word_t    link;
    fwd_sel_t sel_a;
    fwd_sel_t sel_b;
    logic     br_taken;

    assign opcode = instr[6:0];
    assign rd     = instr[11:7];
    assign funct3 = instr[14:12];
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];

    always_comb begin
        case (opcode)
            OP_STORE:         imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            OP_BRANCH:        imm = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
            OP_LUI, OP_AUIPC: imm = {instr[31:12], 12'b0};
            OP_JAL:           imm = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
            default:          imm = {{20{instr[31]}}, instr[31:20]};
        endcase
    end

    // Control from the opcode and gated by valid
    assign reg_write = valid && ((opcode == OP_LUI) || (opcode == OP_AUIPC) ||
                                 (opcode == OP_JAL) || (opcode == OP_JALR) ||
                                 (opcode == OP_LOAD) || (opcode == OP_IMM) ||
                                 (opcode == OP_REG));
    assign mem_read     = valid && (opcode == OP_LOAD);
    assign mem_write    = valid && (opcode == OP_STORE);
    assign branch_taken = valid && br_taken;

    forward_unit u_fwd (
        .rs1   (rs1),
        .rs2   (rs2),
        .byp   (byp),
        .sel_a (sel_a),
        .sel_b (sel_b)
    );

    function automatic word_t fwd_mux(input fwd_sel_t sel, input word_t rf,
                                      input word_t wb, input word_t mem);
        case (sel)
            FWD_MEM: return mem;
            FWD_WB:  return wb;
            default: return rf;
        endcase
    endfunction

    assign fwd_a = fwd_mux(sel_a, rs1_data, byp.wb_data, byp.mem_result);
    assign fwd_b = fwd_mux(sel_b, rs2_data, byp.wb_data, byp.mem_result);
    assign alu_b = (opcode == OP_REG) ? fwd_b : imm;

    alu u_alu (
        .opcode   (opcode),
        .funct3   (funct3),
        .funct7_5 (instr[30]),
        .op_a     (fwd_a),
        .op_b     (alu_b),
        .result   (alu_out)
    );

    branch_unit u_br (
        .opcode  (opcode),
        .funct3  (funct3),
        .pc      (pc),
        .rs1_val (fwd_a),
        .rs2_val (fwd_b),
        .imm     (imm),
        .taken   (br_taken),
        .target  (branch_target),
        .link    (link)
    );

    always_comb begin
        case (opcode)
            OP_LUI:          result = imm;
            OP_AUIPC:        result = pc + imm;
            OP_JAL, OP_JALR: result = link;
            default:         result = alu_out;
        endcase
    end

    assign store_data = fwd_b;

endmodule

// ==== source/ex_mem_reg.sv ====
module ex_mem_reg
    import rv_isa_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     stall,
    input  logic     flush,
    input  logic     ex_valid,
    input  word_t    ex_result,
    input  word_t    ex_store_data,
    input  reg_idx_t ex_rd,
    input  logic     ex_reg_write,
    input  logic     ex_mem_read,
    input  logic     ex_mem_write,
    input  funct3_t  ex_funct3,
    input  logic     ex_branch_taken,
    input  word_t    ex_branch_target,
    bypass_if.source byp,
    output logic     mem_valid,
    output word_t    mem_result,
    output word_t    mem_store_data,
    output reg_idx_t mem_rd,
    output logic     mem_reg_write,
    output logic     mem_read,
    output logic     mem_write,
    output funct3_t  mem_funct3,
    output logic     mem_branch_taken,
    output word_t    mem_branch_target
);

    // Flush loads a bubble into the control bits
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mem_valid        <= 1'b0;
            mem_reg_write    <= 1'b0;
            mem_read         <= 1'b0;
            mem_write        <= 1'b0;
            mem_branch_taken <= 1'b0;
        end else if (!stall) begin
            mem_valid        <= ex_valid && !flush;
            mem_reg_write    <= ex_reg_write && !flush;
            mem_read         <= ex_mem_read && !flush;
            mem_write        <= ex_mem_write && !flush;
            mem_branch_taken <= ex_branch_taken && !flush;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            mem_result        <= ex_result;
            mem_store_data    <= ex_store_data;
            mem_rd            <= ex_rd;
            mem_funct3        <= ex_funct3;
            mem_branch_target <= ex_branch_target;
        end
    end

    assign byp.mem_rd        = mem_rd;
    assign byp.mem_reg_write = mem_reg_write;
    assign byp.mem_is_load   = mem_read;
    assign byp.mem_result    = mem_result;

endmodule

// ==== source/ex_top.sv ====
module ex_top
    import rv_isa_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     id_valid,
    input  word_t    id_instr,
    input  word_t    id_pc,
    input  word_t    id_rs1_data,
    input  word_t    id_rs2_data,
    input  reg_idx_t wb_rd,
    input  logic     wb_write,
    input  word_t    wb_data,
    input  logic     stall,
    input  logic     flush,
    output logic     mem_valid,
    output word_t    mem_result,
    output word_t    mem_store_data,
    output reg_idx_t mem_rd,
    output logic     mem_reg_write,
    output logic     mem_read,
    output logic     mem_write,
    output funct3_t  mem_funct3,
    output logic     mem_branch_taken,
    output word_t    mem_branch_target
);

    bypass_if byp ();

    word_t    ex_result;
    word_t    ex_store_data;
    reg_idx_t ex_rd;
    logic     ex_reg_write;
    logic     ex_mem_read;
    logic     ex_mem_write;
    funct3_t  ex_funct3;
    logic     ex_branch_taken;
    word_t    ex_branch_target;

    // Write-back side of the bypass
    assign byp.wb_rd    = wb_rd;
    assign byp.wb_write = wb_write;
    assign byp.wb_data  = wb_data;

    execute_stage u_ex (
        .valid         (id_valid),
        .instr         (id_instr),
        .pc            (id_pc),
        .rs1_data      (id_rs1_data),
        .rs2_data      (id_rs2_data),
        .byp           (byp),
        .result        (ex_result),
        .store_data    (ex_store_data),
        .rd            (ex_rd),
        .reg_write     (ex_reg_write),
        .mem_read      (ex_mem_read),
        .mem_write     (ex_mem_write),
        .funct3        (ex_funct3),
        .branch_taken  (ex_branch_taken),
        .branch_target (ex_branch_target)
    );

    ex_mem_reg u_exmem (
        .clk               (clk),
        .rst_n             (rst_n),
        .stall             (stall),
        .flush             (flush),
        .ex_valid          (id_valid),
        .ex_result         (ex_result),
        .ex_store_data     (ex_store_data),
        .ex_rd             (ex_rd),
        .ex_reg_write      (ex_reg_write),
        .ex_mem_read       (ex_mem_read),
        .ex_mem_write      (ex_mem_write),
        .ex_funct3         (ex_funct3),
        .ex_branch_taken   (ex_branch_taken),
        .ex_branch_target  (ex_branch_target),
        .byp               (byp),
        .mem_valid         (mem_valid),
        .mem_result        (mem_result),
        .mem_store_data    (mem_store_data),
        .mem_rd            (mem_rd),
        .mem_reg_write     (mem_reg_write),
        .mem_read          (mem_read),
        .mem_write         (mem_write),
        .mem_funct3        (mem_funct3),
        .mem_branch_taken  (mem_branch_taken),
        .mem_branch_target (mem_branch_target)
    );

endmodule

// ==== verification/tb_clock_gen.sv ====
module tb_clock_gen (
    output logic clk,
    output logic rst_n
);

    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Release away from the rising edge
    initial begin
        rst_n = 1'b0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

// ==== verification/ex_tb.sv ====
module ex_tb
    import rv_isa_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    logic     clk;
    logic     rst_n;
    logic     id_valid;
    word_t    id_instr;
    word_t    id_pc;
    word_t    id_rs1_data;
    word_t    id_rs2_data;
    reg_idx_t wb_rd;
    logic     wb_write;
    word_t    wb_data;
    logic     stall;
    logic     flush;
    logic     mem_valid;
    word_t    mem_result;
    word_t    mem_store_data;
    reg_idx_t mem_rd;
    logic     mem_reg_write;
    logic     mem_read;
    logic     mem_write;
    funct3_t  mem_funct3;
    logic     mem_branch_taken;
    word_t    mem_branch_target;

    int          errors;
    logic [31:0] seed;
    word_t       pc;

    // Model of the EX/MEM slot as seen by forwarding
    reg_idx_t m_rd;
    logic     m_fwd;
    word_t    m_result;

    // Expected outputs and which data fields are meaningful
    logic     e_valid;
    logic     e_rw;
    logic     e_ld;
    logic     e_st;
    logic     e_tk;
    word_t    e_res;
    word_t    e_sd;
    word_t    e_tgt;
    reg_idx_t e_rd;
    funct3_t  e_f3;
    logic     chk_res;
    logic     chk_rd;
    logic     chk_sd;
    logic     chk_tgt;

    tb_clock_gen u_clk (
        .clk   (clk),
        .rst_n (rst_n)
    );

    ex_top dut (
        .clk               (clk),
        .rst_n             (rst_n),
        .id_valid          (id_valid),
        .id_instr          (id_instr),
        .id_pc             (id_pc),
        .id_rs1_data       (id_rs1_data),
        .id_rs2_data       (id_rs2_data),
        .wb_rd             (wb_rd),
        .wb_write          (wb_write),
        .wb_data           (wb_data),
        .stall             (stall),
        .flush             (flush),
        .mem_valid         (mem_valid),
        .mem_result        (mem_result),
        .mem_store_data    (mem_store_data),
        .mem_rd            (mem_rd),
        .mem_reg_write     (mem_reg_write),
        .mem_read          (mem_read),
        .mem_write         (mem_write),
        .mem_funct3        (mem_funct3),
        .mem_branch_taken  (mem_branch_taken),
        .mem_branch_target (mem_branch_target)
    );

    function automatic word_t lcg_next();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    function automatic word_t r_ins(logic [6:0] f7, reg_idx_t rs2, reg_idx_t rs1,
                                    funct3_t f3, reg_idx_t rd);
        return {f7, rs2, rs1, f3, rd, OP_REG};
    endfunction

    function automatic word_t i_ins(logic [11:0] imm, reg_idx_t rs1, funct3_t f3,
                                    reg_idx_t rd, opcode_t op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic word_t s_ins(logic [11:0] imm, reg_idx_t rs2, reg_idx_t rs1,
                                    funct3_t f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], OP_STORE};
    endfunction

    function automatic word_t b_ins(logic [12:0] imm, reg_idx_t rs2, reg_idx_t rs1,
                                    funct3_t f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OP_BRANCH};
    endfunction

    function automatic word_t j_ins(logic [20:0] imm, reg_idx_t rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OP_JAL};
    endfunction

    // Immediate by instruction format
    function automatic word_t imm_of(word_t i);
        case (i[6:0])
            OP_STORE:         return {{20{i[31]}}, i[31:25], i[11:7]};
            OP_BRANCH:        return {{19{i[31]}}, i[31], i[7], i[30:25], i[11:8], 1'b0};
            OP_LUI, OP_AUIPC: return {i[31:12], 12'h000};
            OP_JAL:           return {{11{i[31]}}, i[31], i[19:12], i[20], i[30:21], 1'b0};
            default:          return {{20{i[31]}}, i[31:20]};
        endcase
    endfunction

    function automatic word_t operand(reg_idx_t rs, word_t rf);
        if (m_fwd && rs != 5'd0 && m_rd == rs) begin
            return m_result;
        end else if (wb_write && wb_rd != 5'd0 && wb_rd == rs) begin
            return wb_data;
        end
        return rf;
    endfunction

    function automatic word_t alu_ref(word_t ins, word_t a, word_t b);
        logic alt;
        alt = ins[30];
        case (ins[14:12])
            3'd0:    return (ins[6:0] == OP_REG && alt) ? a - b : a + b;
            3'd1:    return a << b[4:0];
            3'd2:    return {31'b0, $signed(a) < $signed(b)};
            3'd3:    return {31'b0, a < b};
            3'd4:    return a ^ b;
            3'd5:    return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic cond_ref(funct3_t f3, word_t a, word_t b);
        case (f3)
            F3_BEQ:  return a == b;
            F3_BNE:  return a != b;
            F3_BLT:  return $signed(a) < $signed(b);
            F3_BGE:  return $signed(a) >= $signed(b);
            F3_BLTU: return a < b;
            F3_BGEU: return a >= b;
            default: return 1'b0;
        endcase
    endfunction

    task automatic check_val(string name, string field, logic [31:0] exp, logic [31:0] act);
        assert (exp === act) else begin
            $display("MISMATCH %s %s expected %h actual %h", name, field, exp, act);
            errors++;
        end
    endtask

    task automatic check_ctrl_zero(string name);
        check_val(name, "mem_valid", 32'd0, 32'(mem_valid));
        check_val(name, "mem_reg_write", 32'd0, 32'(mem_reg_write));
        check_val(name, "mem_read", 32'd0, 32'(mem_read));
        check_val(name, "mem_write", 32'd0, 32'(mem_write));
        check_val(name, "mem_branch_taken", 32'd0, 32'(mem_branch_taken));
    endtask

    task automatic check_outputs(string name);
        check_val(name, "mem_valid", 32'(e_valid), 32'(mem_valid));
        check_val(name, "mem_reg_write", 32'(e_rw), 32'(mem_reg_write));
        check_val(name, "mem_read", 32'(e_ld), 32'(mem_read));
        check_val(name, "mem_write", 32'(e_st), 32'(mem_write));
        check_val(name, "mem_branch_taken", 32'(e_tk), 32'(mem_branch_taken));
        if (e_valid) begin
            check_val(name, "mem_funct3", 32'(e_f3), 32'(mem_funct3));
        end
        if (chk_res) begin
            check_val(name, "mem_result", e_res, mem_result);
        end
        if (chk_rd) begin
            check_val(name, "mem_rd", 32'(e_rd), 32'(mem_rd));
        end
        if (chk_sd) begin
            check_val(name, "mem_store_data", e_sd, mem_store_data);
        end
        if (chk_tgt) begin
            check_val(name, "mem_branch_target", e_tgt, mem_branch_target);
        end
    endtask

    task automatic set_wb(reg_idx_t rd, logic we, word_t data);
        wb_rd    = rd;
        wb_write = we;
        wb_data  = data;
    endtask

    // Drives one instruction, predicts the EX/MEM slot and checks it after the edge
    task automatic run_instr(string name, word_t ins, word_t a, word_t b, logic st, logic fl);
        opcode_t op;
        word_t   imm;
        word_t   op_a;
        word_t   op_b;
        word_t   res;
        word_t   tgt;
        logic    rw;
        logic    tk;
        logic    is_br;
        logic    is_jmp;
        op     = ins[6:0];
        imm    = imm_of(ins);
        op_a   = operand(ins[19:15], a);
        op_b   = operand(ins[24:20], b);
        is_br  = (op == OP_BRANCH);
        is_jmp = (op == OP_JAL) || (op == OP_JALR);
        case (op)
            OP_LUI:          res = imm;
            OP_AUIPC:        res = pc + imm;
            OP_JAL, OP_JALR: res = pc + 32'd4;
            OP_REG:          res = alu_ref(ins, op_a, op_b);
            OP_IMM:          res = alu_ref(ins, op_a, imm);
            default:         res = op_a + imm;
        endcase
        rw  = op inside {OP_LUI, OP_AUIPC, OP_JAL, OP_JALR, OP_LOAD, OP_IMM, OP_REG};
        tk  = is_jmp || (is_br && cond_ref(ins[14:12], op_a, op_b));
        tgt = (op == OP_JALR) ? ((op_a + imm) & ~32'd1) : pc + imm;
        id_valid    = 1'b1;
        id_instr    = ins;
        id_pc       = pc;
        id_rs1_data = a;
        id_rs2_data = b;
        stall       = st;
        flush       = fl;
        @(posedge clk);
        #1;
        if (!st) begin
            e_valid  = !fl;
            e_rw     = rw && !fl;
            e_ld     = (op == OP_LOAD) && !fl;
            e_st     = (op == OP_STORE) && !fl;
            e_tk     = tk && !fl;
            e_res    = res;
            e_sd     = op_b;
            e_tgt    = tgt;
            e_rd     = ins[11:7];
            e_f3     = ins[14:12];
            chk_res  = !fl && !is_br;
            chk_rd   = e_rw;
            chk_sd   = e_st;
            chk_tgt  = !fl && (is_br || is_jmp);
            m_rd     = e_rd;
            m_fwd    = e_rw && !e_ld;
            m_result = res;
            pc       = pc + 32'd4;
        end else begin
            // Held store data is the forwarded rs2 of the held slot
            chk_sd   = 1'b1;
        end
        check_outputs(name);
    endtask

    initial begin
        #100000;
        $display("Simulation did not finish in time");
        $display("TEST RESULT: FAIL");
        $finish;
    end

    initial begin
        int          n;
        word_t       r;
        word_t       ins;
        funct3_t     f3;
        reg_idx_t    rd;
        logic [11:0] imm12;
        word_t       ins_hold;
        funct3_t     conds[6];
        word_t       pa[3];
        word_t       pb[3];
        conds = '{F3_BEQ, F3_BNE, F3_BLT, F3_BGE, F3_BLTU, F3_BGEU};
        pa    = '{32'h0000_0042, 32'hffff_fffb, 32'h0000_0003};
        pb    = '{32'h0000_0042, 32'h0000_0003, 32'hffff_fffb};
        errors = 0;
        seed   = 32'h0ad4_7194;
        pc     = 32'h0000_1000;
        m_rd   = 5'd0;
        m_fwd  = 1'b0;
        m_result = 32'd0;
        id_valid = 1'b0;
        id_instr = 32'd0;
        id_pc    = 32'd0;
        id_rs1_data = 32'd0;
        id_rs2_data = 32'd0;
        stall = 1'b0;
        flush = 1'b0;
        set_wb(5'd0, 1'b0, 32'd0);

        n = 0;
        while (rst_n !== 1'b1 && n < 40) begin
            @(posedge clk);
            #1;
            check_ctrl_zero("reset");
            // Live instructions early in reset, idle before release
            id_valid = (n < 8);
            case (n % 4)
                0:       id_instr = r_ins(7'h00, 5'd2, 5'd1, 3'd0, 5'd3);
                1:       id_instr = i_ins(12'h000, 5'd1, 3'd2, 5'd3, OP_LOAD);
                2:       id_instr = s_ins(12'h000, 5'd2, 5'd1, 3'd2);
                default: id_instr = j_ins(21'd8, 5'd1);
            endcase
            n++;
        end
        if (rst_n !== 1'b1) begin
            $display("Reset was never released");
            $display("TEST RESULT: FAIL");
            $finish;
        end
        @(posedge clk);
        #1;
        check_ctrl_zero("after_reset");

        for (int i = 0; i < 40; i++) begin
            r  = lcg_next();
            rd = r[6:2];
            f3 = r[9:7];
            case (r[1:0])
                2'd0: begin
                    ins = r_ins((f3 == 3'd0 || f3 == 3'd5) && r[10] ? 7'h20 : 7'h00,
                                r[20:16], r[15:11], f3, rd);
                end
                2'd1: begin
                    imm12 = r[31:20];
                    if (f3 == 3'd1) begin
                        imm12 = {7'h00, r[24:20]};
                    end else if (f3 == 3'd5) begin
                        imm12 = {r[10] ? 7'h20 : 7'h00, r[24:20]};
                    end
                    ins = i_ins(imm12, r[15:11], f3, rd, OP_IMM);
                end
                2'd2:    ins = {r[31:12], rd, OP_LUI};
                default: ins = {r[31:12], rd, OP_AUIPC};
            endcase
            run_instr("arith", ins, lcg_next(), lcg_next(), 1'b0, 1'b0);
        end

        run_instr("fwd_prod", r_ins(7'h00, 5'd2, 5'd1, 3'd0, 5'd5), lcg_next(), lcg_next(),
                  1'b0, 1'b0);
        run_instr("fwd_mem", r_ins(7'h00, 5'd5, 5'd5, 3'd0, 5'd6), lcg_next(), lcg_next(),
                  1'b0, 1'b0);
        set_wb(5'd6, 1'b1, 32'h1234_5678);
        run_instr("fwd_mem_over_wb", r_ins(7'h00, 5'd2, 5'd6, 3'd4, 5'd7), lcg_next(),
                  lcg_next(), 1'b0, 1'b0);
        set_wb(5'd3, 1'b1, 32'h0bad_cafe);
        run_instr("fwd_wb", r_ins(7'h00, 5'd3, 5'd3, 3'd6, 5'd8), lcg_next(), lcg_next(),
                  1'b0, 1'b0);
        set_wb(5'd0, 1'b1, 32'h5555_aaaa);
        run_instr("x0_prod", i_ins(12'h055, 5'd1, 3'd0, 5'd0, OP_IMM), lcg_next(),
                  lcg_next(), 1'b0, 1'b0);
        run_instr("fwd_x0", r_ins(7'h00, 5'd0, 5'd0, 3'd0, 5'd9), lcg_next(), lcg_next(),
                  1'b0, 1'b0);
        set_wb(5'd0, 1'b0, 32'd0);
        run_instr("load", i_ins(12'h010, 5'd1, 3'd2, 5'd12, OP_LOAD), lcg_next(),
                  lcg_next(), 1'b0, 1'b0);
        run_instr("no_fwd_load", r_ins(7'h00, 5'd12, 5'd12, 3'd0, 5'd13), lcg_next(),
                  lcg_next(), 1'b0, 1'b0);
        run_instr("store_prod", i_ins(12'h7ff, 5'd1, 3'd0, 5'd14, OP_IMM), lcg_next(),
                  lcg_next(), 1'b0, 1'b0);
        run_instr("store", s_ins(12'hff8, 5'd14, 5'd1, 3'd2), lcg_next(), lcg_next(),
                  1'b0, 1'b0);

        foreach (conds[c]) begin
            for (int k = 0; k < 3; k++) begin
                r = lcg_next();
                run_instr("branch", b_ins({r[12:1], 1'b0}, 5'd2, 5'd1, conds[c]), pa[k], pb[k],
                          1'b0, 1'b0);
            end
        end
        r = lcg_next();
        run_instr("jal", j_ins({r[20:1], 1'b0}, 5'd1), lcg_next(), lcg_next(), 1'b0, 1'b0);
        // Odd base with an even offset so bit 0 must be cleared
        run_instr("jalr", i_ins({r[11:1], 1'b0}, 5'd3, 3'd0, 5'd1, OP_JALR),
                  lcg_next() | 32'd1, lcg_next(), 1'b0, 1'b0);

        r = lcg_next();
        run_instr("stall_prod", j_ins({r[20:1], 1'b0}, 5'd15), lcg_next(), lcg_next(),
                  1'b0, 1'b0);
        ins_hold = r_ins(7'h20, 5'd15, 5'd4, 3'd0, 5'd16);
        r = lcg_next();
        run_instr("stall", ins_hold, r, ~r, 1'b1, 1'b0);
        run_instr("stall", ins_hold, r, ~r, 1'b1, 1'b0);
        run_instr("stall_release", ins_hold, r, ~r, 1'b0, 1'b0);
        run_instr("flush_store", s_ins(12'h00c, 5'd16, 5'd2, 3'd2), lcg_next(),
                  lcg_next(), 1'b0, 1'b1);
        r = lcg_next();
        run_instr("flush_jal", j_ins({r[20:1], 1'b0}, 5'd19), lcg_next(), lcg_next(),
                  1'b0, 1'b1);
        run_instr("flush", i_ins(12'h004, 5'd16, 3'd2, 5'd17, OP_LOAD), lcg_next(),
                  lcg_next(), 1'b0, 1'b1);
        run_instr("after_flush", r_ins(7'h00, 5'd17, 5'd16, 3'd0, 5'd18), lcg_next(),
                  lcg_next(), 1'b0, 1'b0);

        $display("Checks done, errors: %0d", errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== sim.f ====
common/rv_isa_pkg.sv
common/ex_pipe_pkg.sv
common/bypass_if.sv
execute/forward_unit.sv
execute/alu.sv
execute/branch_unit.sv
execute/execute_stage.sv
source/ex_mem_reg.sv
source/ex_top.sv
verification/tb_clock_gen.sv
verification/ex_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f sim.f --top-module ex_tb -o ex_sim

out=$(./obj_dir/ex_sim)
echo "$out"

# Exit status follows the search for the pass line
echo "$out" | grep -q "TEST RESULT: PASS"
